/* verilog.f */
src/sys1_bus_pkg.sv
src/sys1_crypt_pkg.sv
src/main_decode.sv
src/prg_decrypt.sv
src/work_ram.sv
src/read_select.sv
src/main_board.sv
bench/main_board_tb.sv

/* Makefile */
.PHONY: run clean

run: obj_dir/Vmain_board_tb
	@out=$$(./obj_dir/Vmain_board_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

obj_dir/Vmain_board_tb: verilog.f $(wildcard src/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module main_board_tb -f verilog.f --Mdir obj_dir -o Vmain_board_tb

clean:
	rm -rf obj_dir

/* bench/main_board_tb.sv */
// random ROM model and a 100 ns clock; every result is expected exactly two or one edges after presentation
`default_nettype none
`timescale 1ns/10ps

module main_board_tb;

	import sys1_bus_pkg::*;
	import sys1_crypt_pkg::*;

	localparam int ram_aw = 12;
	localparam int n_rom = 200;
	localparam int n_ram = 32;
	localparam int n_b2b = 32;
	// held accesses, back-to-back accesses and drain cycles
	localparam int n_access = 2 * n_rom + 2 * n_ram + 32 + 8 + 16 + n_b2b + 4;
	localparam int timeout_cycles = n_access * 4 + 200;

	logic        CPUCLn;
	logic        reset;
	logic [15:0] adr;
	logic [7:0]  dout;
	logic        m1, mreq, iorq, rd, wr;
	logic [7:0]  in0, in1, in2, dsw0, dsw1;
	logic        vid_cs;
	logic [7:0]  vid_do;
	logic [7:0]  rom_do;
	logic [7:0]  din;
	logic [14:0] rom_addr;
	logic        mem_wr;
	logic        snd_rq;
	logic [7:0]  vid_mode;

	logic [7:0]  rom_mem [0:32767];
	logic [7:0]  shadow [0:(1 << ram_aw) - 1];
	logic [7:0]  exp_vid = 8'h00;
	integer      seed;
	int          cyc = 0;
	int          pulse_due [$];
	logic [9:0]  pulse_exp [$];
	logic [14:0] addr_exp [$];
	int          din_due [$];
	logic [7:0]  din_exp [$];
	logic [15:0] ram_used [$];

	main_board #(
		.RAM_AW(ram_aw)
	) dut0 (
		.CPUCLn(CPUCLn), .reset(reset), .adr(adr), .dout(dout), .m1(m1), .mreq(mreq),
		.iorq(iorq), .rd(rd), .wr(wr), .din(din), .in0(in0), .in1(in1), .in2(in2),
		.dsw0(dsw0), .dsw1(dsw1), .vid_cs(vid_cs), .vid_do(vid_do), .rom_addr(rom_addr),
		.rom_do(rom_do), .mem_wr(mem_wr), .snd_rq(snd_rq), .vid_mode(vid_mode)
	);

	// external ROM answers in the same cycle
	assign rom_do = rom_mem[rom_addr];

	always #50 CPUCLn = ~CPUCLn;

	always @(posedge CPUCLn) begin
		cyc <= cyc + 1;
		if (cyc == timeout_cycles) begin
			$display("timeout after %0d cycles without finishing the tests", cyc);
			$display("Simulation FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h at cycle %0d", name, got, exp, cyc);
			$display("Simulation FAILED");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic check_pulse(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h at cycle %0d", name, got, exp, cyc);
			$display("Simulation FAILED");
			$fatal(1, "pulse mismatch");
		end
	endtask

	task automatic check_addr(input string name, input logic [14:0] got,
			input logic [14:0] exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h at cycle %0d", name, got, exp, cyc);
			$display("Simulation FAILED");
			$fatal(1, "address mismatch");
		end
	endtask

	// --------------------
	// reference model
	// --------------------

	function automatic logic [7:0] ref_read(input logic [15:0] a, input logic m1_i,
			input logic mreq_i, input logic iorq_i, input logic vcs_i, input logic [7:0] vdo);
		logic [7:0] c;
		logic [7:0] res;
		logic       f;
		logic [6:0] idx;
		res = open_bus;
		if (vcs_i) begin
			res = vdo;
		end else if (iorq_i) begin
			case (a[4:0]) inside
				[5'h00:5'h03]: res = in0;
				[5'h04:5'h07]: res = in1;
				[5'h08:5'h0B]: res = in2;
				5'h0C, 5'h0E:  res = dsw0;
				5'h0D, 5'h0F, 5'h10: res = dsw1;
				default:       res = open_bus;
			endcase
		end else if (mreq_i) begin
			if (!a[15]) begin
				c = rom_mem[a[14:0]];
				f = c[7];
				idx = {a[12], a[8], a[4], a[0], ~m1_i, c[5] ^ f, c[3] ^ f};
				res = (c & dec_and_mask) | (dec_table[idx] ^ {f, 1'b0, f, 1'b0, f, 3'b000});
			end else if (a[15:12] == ram_base_hi) begin
				res = shadow[a[ram_aw-1:0]];
			end
		end
		return res;
	endfunction

	// one bus cycle from falling edge to falling edge, queueing what it should produce
	task automatic drive_cycle(input logic [15:0] a, input logic [7:0] d, input logic m1_i,
			input logic mreq_i, input logic iorq_i, input logic wr_i, input logic vcs_i,
			input logic [7:0] vdo);
		logic active;
		active = mreq_i | iorq_i | vcs_i;
		adr = a;
		dout = d;
		m1 = m1_i;
		mreq = mreq_i;
		iorq = iorq_i;
		wr = wr_i;
		rd = active & ~wr_i;
		vid_cs = vcs_i;
		vid_do = vdo;
		if (mreq_i && wr_i && a[15:12] == ram_base_hi) begin
			shadow[a[ram_aw-1:0]] = d;
		end
		if (iorq_i && wr_i && a[4:0] == io_vid_mode) begin
			exp_vid = d;
		end
		pulse_due.push_back(cyc + 1);
		pulse_exp.push_back({mreq_i & wr_i, iorq_i & wr_i & (a[4:0] == io_snd_req), exp_vid});
		// the ROM address follows the bus one edge later
		addr_exp.push_back(a[14:0]);
		if (active && !wr_i) begin
			din_due.push_back(cyc + 2);
			din_exp.push_back(ref_read(a, m1_i, mreq_i, iorq_i, vcs_i, vdo));
		end
		@(negedge CPUCLn);
	endtask

	// --------------------
	// compare process
	// --------------------

	always @(negedge CPUCLn) begin
		if (pulse_due.size() > 0 && pulse_due[0] == cyc) begin
			check_pulse("mem_wr", mem_wr, pulse_exp[0][9]);
			check_pulse("snd_rq", snd_rq, pulse_exp[0][8]);
			check_byte("vid_mode", vid_mode, pulse_exp[0][7:0]);
			check_addr("rom_addr", rom_addr, addr_exp[0]);
			pulse_due.delete(0);
			pulse_exp.delete(0);
			addr_exp.delete(0);
		end
		if (din_due.size() > 0 && din_due[0] == cyc) begin
			check_byte("din", din, din_exp[0]);
			din_due.delete(0);
			din_exp.delete(0);
		end
	end

	// --------------------
	// stimulus
	// --------------------

	initial begin
		int          i;
		int          r;
		logic [15:0] a;
		logic [3:0]  hi;
		CPUCLn = 1'b0;
		reset = 1'b1;
		seed = 52093;
		for (i = 0; i < 32768; i++) begin
			r = $random(seed);
			rom_mem[i] = r[7:0];
		end
		r = $random(seed);
		{in0, in1, in2, dsw0} = r;
		r = $random(seed);
		dsw1 = r[7:0];
		adr = 16'h0000;
		dout = 8'h00;
		{m1, mreq, iorq, rd, wr, vid_cs} = 6'b000000;
		vid_do = 8'h00;
		repeat (10) @(negedge CPUCLn);
		reset = 1'b0;
		check_byte("din", din, open_bus);
		check_byte("vid_mode", vid_mode, 8'h00);
		check_pulse("mem_wr", mem_wr, 1'b0);
		check_pulse("snd_rq", snd_rq, 1'b0);

		// opcode and data fetches of the same ROM address
		for (i = 0; i < n_rom; i++) begin
			r = $random(seed);
			a = {1'b0, r[14:0]};
			repeat (3) drive_cycle(a, 8'h00, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 8'h00);
			repeat (3) drive_cycle(a, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h00);
		end
		for (i = 0; i < n_ram; i++) begin
			r = $random(seed);
			a = {ram_base_hi, r[11:0]};
			ram_used.push_back(a);
			repeat (3) drive_cycle(a, r[23:16], 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 8'h00);
		end
		for (i = 0; i < n_ram; i++) begin
			repeat (3) drive_cycle(ram_used[i], 8'h00, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h00);
		end
		// port map with random mirror bits above adr[4:0]
		for (i = 0; i < 32; i++) begin
			r = $random(seed);
			repeat (3) drive_cycle({r[10:0], i[4:0]}, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 8'h00);
		end
		for (i = 0; i < 4; i++) begin
			r = $random(seed);
			repeat (3) drive_cycle({11'h000, io_snd_req}, r[7:0], 1'b0, 1'b0, 1'b1, 1'b1, 1'b0,
				8'h00);
			repeat (3) drive_cycle({11'h000, io_vid_mode}, r[15:8], 1'b0, 1'b0, 1'b1, 1'b1, 1'b0,
				8'h00);
		end
		// video window over ports and memory, then unmapped memory
		for (i = 0; i < 8; i++) begin
			r = $random(seed);
			repeat (3) drive_cycle(r[15:0], 8'h00, r[16], i[0], ~i[0], 1'b0, 1'b1, r[31:24]);
		end
		for (i = 0; i < 8; i++) begin
			r = $random(seed);
			hi = (i == 4) ? 4'hF : 4'h8 + i[3:0];
			repeat (3) drive_cycle({hi, r[11:0]}, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h00);
		end
		// a new access every cycle, each RAM write read back on the next cycle
		for (i = 0; i < n_b2b; i++) begin
			r = $random(seed);
			case (i % 4)
				0: drive_cycle({1'b0, r[14:0]}, 8'h00, r[16], 1'b1, 1'b0, 1'b0, 1'b0, 8'h00);
				1: drive_cycle({11'h000, r[4:0]}, 8'h00, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 8'h00);
				2: begin
					a = {ram_base_hi, r[11:0]};
					ram_used.push_back(a);
					drive_cycle(a, r[23:16], 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 8'h00);
				end
				default: drive_cycle(ram_used[$], 8'h00, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 8'h00);
			endcase
		end
		repeat (4) drive_cycle(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'h00);
		// let the compare process finish the last due entry
		@(negedge CPUCLn);

		if (din_due.size() == 0 && pulse_due.size() == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("some expected results were never compared");
			$display("Simulation FAILED");
			$fatal(1, "unchecked results");
		end
	end

endmodule

`default_nettype wire

/* src/main_board.sv */
// main CPU board glue for a Z80 style bus with the ROM outside and no interrupt source
`default_nettype none
`timescale 1ns/10ps

module main_board #(
	parameter int RAM_AW = 12
) (
	input  wire         CPUCLn,
	input  wire         reset,

	// cpu bus
	input  wire  [15:0] adr,
	input  wire  [7:0]  dout,
	input  wire         m1,
	input  wire         mreq,
	input  wire         iorq,
	input  wire         rd,
	input  wire         wr,
	output logic [7:0]  din,

	// player inputs and dip switches
	input  wire  [7:0]  in0,
	input  wire  [7:0]  in1,
	input  wire  [7:0]  in2,
	input  wire  [7:0]  dsw0,
	input  wire  [7:0]  dsw1,

	// video board read window
	input  wire         vid_cs,
	input  wire  [7:0]  vid_do,

	// external program rom
	output logic [14:0] rom_addr,
	input  wire  [7:0]  rom_do,

	output logic        mem_wr,
	output logic        snd_rq,
	output logic [7:0]  vid_mode
);

	import sys1_bus_pkg::*;

	rd_src_t           rd_src;
	logic [15:0]       reg_adr;
	logic              reg_m1;
	logic [7:0]        reg_vid_do;
	logic              ram_we;
	logic [RAM_AW-1:0] ram_addr;
	logic [7:0]        ram_wdata;
	logic [7:0]        ram_do;
	logic [7:0]        rom_plain;

	// --------------------
	// decode
	// --------------------

	main_decode #(
		.RAM_AW(RAM_AW)
	) u_decode (
		.CPUCLn     (CPUCLn),
		.reset      (reset),
		.adr        (adr),
		.dout       (dout),
		.m1         (m1),
		.mreq       (mreq),
		.iorq       (iorq),
		.rd         (rd),
		.wr         (wr),
		.vid_cs     (vid_cs),
		.vid_do     (vid_do),
		.rd_src     (rd_src),
		.reg_adr    (reg_adr),
		.reg_m1     (reg_m1),
		.reg_vid_do (reg_vid_do),
		.ram_we     (ram_we),
		.ram_addr   (ram_addr),
		.ram_wdata  (ram_wdata),
		.mem_wr     (mem_wr),
		.snd_rq     (snd_rq),
		.vid_mode   (vid_mode)
	);

	// --------------------
	// execute
	// --------------------

	prg_decrypt u_decrypt (
		.reg_adr   (reg_adr[14:0]),
		.reg_m1    (reg_m1),
		.rom_do    (rom_do),
		.rom_addr  (rom_addr),
		.rom_plain (rom_plain)
	);

	// read side taps the raw bus so data lines up with the decode registers
	work_ram #(
		.RAM_AW(RAM_AW)
	) u_ram (
		.CPUCLn (CPUCLn),
		.we     (ram_we),
		.waddr  (ram_addr),
		.raddr  (adr[RAM_AW-1:0]),
		.wdata  (ram_wdata),
		.rdata  (ram_do)
	);

	// --------------------
	// result
	// --------------------

	read_select u_select (
		.CPUCLn    (CPUCLn),
		.reset     (reset),
		.rd_src    (rd_src),
		.in0       (in0),
		.in1       (in1),
		.in2       (in2),
		.dsw0      (dsw0),
		.dsw1      (dsw1),
		.vid_do    (reg_vid_do),
		.ram_do    (ram_do),
		.rom_plain (rom_plain),
		.din       (din)
	);

endmodule

`default_nettype wire

/* src/read_select.sv */
// CPU read mux that registers one byte per cycle and shows open bus for unmapped reads
`default_nettype none
`timescale 1ns/10ps

module read_select (
	input  wire                   CPUCLn,
	input  wire                   reset,
	input  sys1_bus_pkg::rd_src_t rd_src,
	input  wire  [7:0]            in0,
	input  wire  [7:0]            in1,
	input  wire  [7:0]            in2,
	input  wire  [7:0]            dsw0,
	input  wire  [7:0]            dsw1,
	input  wire  [7:0]            vid_do,
	input  wire  [7:0]            ram_do,
	input  wire  [7:0]            rom_plain,
	output logic [7:0]            din
);

	import sys1_bus_pkg::*;

	logic [7:0] sel_byte;

	// --------------------
	// source mux
	// --------------------

	always_comb begin
		case (rd_src)
			src_video: sel_byte = vid_do;
			src_in0:   sel_byte = in0;
			src_in1:   sel_byte = in1;
			src_in2:   sel_byte = in2;
			src_dsw0:  sel_byte = dsw0;
			src_dsw1:  sel_byte = dsw1;
			src_ram:   sel_byte = ram_do;
			src_rom:   sel_byte = rom_plain;
			default:   sel_byte = open_bus;
		endcase
	end

	// --------------------
	// output register
	// --------------------

	// second pipeline edge
	always_ff @(posedge CPUCLn) begin
		if (reset) begin
			din <= open_bus;
		end else begin
			din <= sel_byte;
		end
	end

	// decode stage must hand over a clean source once out of reset
	a_src_known: assert property (@(posedge CPUCLn) disable iff (reset)
		!$isunknown(rd_src))
		else $error("rd_src unknown after reset");

endmodule

`default_nettype wire

/* src/work_ram.sv */
// single clock work RAM with a registered read and no reset on its contents
`default_nettype none
`timescale 1ns/10ps

module work_ram #(
	parameter int RAM_AW = 12
) (
	input  wire               CPUCLn,
	input  wire               we,
	input  wire  [RAM_AW-1:0] waddr,
	input  wire  [RAM_AW-1:0] raddr,
	input  wire  [7:0]        wdata,
	output logic [7:0]        rdata
);

	localparam int DEPTH = 1 << RAM_AW;

	logic [7:0] mem [0:DEPTH-1];

	// write lands one edge after the decode stage
	always_ff @(posedge CPUCLn) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// write-first forwarding so a read right behind a write sees the new byte
	always_ff @(posedge CPUCLn) begin
		if (we && (waddr == raddr)) begin
			rdata <= wdata;
		end else begin
			rdata <= mem[raddr];
		end
	end

	// a write to an unknown address would corrupt the whole array in simulation
	a_waddr_known: assert property (@(posedge CPUCLn)
		we |-> !$isunknown(waddr))
		else $error("work_ram write with unknown address");

endmodule

`default_nettype wire

/* src/prg_decrypt.sv */
// combinational ROM decryptor that needs the external ROM to answer within the same cycle
`default_nettype none
`timescale 1ns/10ps

module prg_decrypt (
	input  wire  [14:0] reg_adr,
	input  wire         reg_m1,
	input  wire  [7:0]  rom_do,
	output logic [14:0] rom_addr,
	output logic [7:0]  rom_plain
);

	import sys1_crypt_pkg::*;

	logic       flag;
	logic [6:0] tbl_idx;
	logic [7:0] tbl_val;
	logic [7:0] flip;
	logic [7:0] kept;

	// --------------------
	// rom access
	// --------------------

	// address comes straight from the decode registers
	assign rom_addr = reg_adr;

	// --------------------
	// decryption
	// --------------------

	// top bit of the cipher byte selects the flipped half
	assign flag = rom_do[7];

	// index mixes address bits with the opcode fetch flag
	assign tbl_idx = dec_index(reg_adr, reg_m1, rom_do);

	assign tbl_val = dec_table[tbl_idx];

	// flag copied onto bits 7, 5 and 3
	assign flip = {8{flag}} & dec_xor_mask;

	// bits 6, 4, 2, 1 and 0 are not encrypted
	assign kept = rom_do & dec_and_mask;

	assign rom_plain = kept | (tbl_val ^ flip);

endmodule

`default_nettype wire

/* src/main_decode.sv */
// bus decode stage that expects exclusive mreq and iorq and ignores rd for source choice
`default_nettype none
`timescale 1ns/10ps

module main_decode #(
	parameter int RAM_AW = 12
) (
	input  wire                    CPUCLn,
	input  wire                    reset,
	input  wire  [15:0]            adr,
	input  wire  [7:0]             dout,
	input  wire                    m1,
	input  wire                    mreq,
	input  wire                    iorq,
	input  wire                    rd,
	input  wire                    wr,
	input  wire                    vid_cs,
	input  wire  [7:0]             vid_do,
	output sys1_bus_pkg::rd_src_t  rd_src,
	output logic [15:0]            reg_adr,
	output logic                   reg_m1,
	output logic [7:0]             reg_vid_do,
	output logic                   ram_we,
	output logic [RAM_AW-1:0]      ram_addr,
	output logic [7:0]             ram_wdata,
	output logic                   mem_wr,
	output logic                   snd_rq,
	output logic [7:0]             vid_mode
);

	import sys1_bus_pkg::*;

	rd_src_t src_next;
	logic    ram_hit;
	logic    io_wr;

	assign ram_hit = (adr[15:12] == ram_base_hi);
	assign io_wr   = iorq & wr;

	// --------------------
	// source priority
	// --------------------

	always_comb begin
		src_next = src_none;
		if (vid_cs) begin
			src_next = src_video;
		end else if (iorq) begin
			case (adr[4:0])
				5'h00, 5'h01, 5'h02, 5'h03: src_next = src_in0;
				5'h04, 5'h05, 5'h06, 5'h07: src_next = src_in1;
				5'h08, 5'h09, 5'h0A, 5'h0B: src_next = src_in2;
				5'h0C, 5'h0E:               src_next = src_dsw0;
				5'h0D, 5'h0F, 5'h10:        src_next = src_dsw1;
				default:                    src_next = src_none;
			endcase
		end else if (mreq) begin
			if (!adr[15]) begin
				src_next = src_rom;
			end else if (ram_hit) begin
				src_next = src_ram;
			end
		end
	end

	// --------------------
	// control registers
	// --------------------

	always_ff @(posedge CPUCLn) begin
		if (reset) begin
			rd_src   <= src_none;
			ram_we   <= 1'b0;
			mem_wr   <= 1'b0;
			snd_rq   <= 1'b0;
			vid_mode <= 8'h00;
		end else begin
			rd_src <= src_next;
			ram_we <= mreq & wr & ram_hit;
			mem_wr <= mreq & wr;
			// high for every cycle the port write is held
			snd_rq <= io_wr & (adr[4:0] == io_snd_req);
			if (io_wr && (adr[4:0] == io_vid_mode)) begin
				vid_mode <= dout;
			end
		end
	end

	// address and data travel alongside rd_src
	always_ff @(posedge CPUCLn) begin
		reg_adr    <= adr;
		reg_m1     <= m1;
		reg_vid_do <= vid_do;
		ram_addr   <= adr[RAM_AW-1:0];
		ram_wdata  <= dout;
	end

	// the CPU never opens a memory and an I/O cycle together
	a_mreq_iorq_excl: assert property (@(posedge CPUCLn) disable iff (reset)
		!(mreq && iorq))
		else $error("mreq and iorq both high");

	// read and write strobes never overlap on the bus
	a_rd_wr_excl: assert property (@(posedge CPUCLn) disable iff (reset)
		!(rd && wr))
		else $error("rd and wr both high");

endmodule

`default_nettype wire

/* src/sys1_crypt_pkg.sv */
// program ROM decryption table for one fixed key and no table download
`default_nettype none

package sys1_crypt_pkg;

	// plaintext bits that pass straight through
	localparam logic [7:0] dec_and_mask = 8'h57;

	// bits 7, 5 and 3 come from the table and flip with the flag bit
	localparam logic [7:0] dec_xor_mask = 8'hA8;

	// --------------------
	// substitution table
	// --------------------

	// index bit 2 is the inverted m1 so opcode and data halves sit side by side
	localparam logic [7:0] dec_table [0:127] = '{
		8'hA0, 8'h88, 8'h28, 8'h80, 8'h88, 8'h20, 8'hA0, 8'h08,
		8'h28, 8'hA8, 8'h00, 8'h88, 8'h20, 8'h88, 8'hA8, 8'h80,
		8'h80, 8'h00, 8'hA8, 8'h20, 8'hA8, 8'h08, 8'h20, 8'hA0,
		8'h08, 8'hA0, 8'h88, 8'h28, 8'h00, 8'hA8, 8'h80, 8'h28,
		8'hA8, 8'h20, 8'h80, 8'h00, 8'h80, 8'hA0, 8'h08, 8'h88,
		8'h88, 8'h08, 8'hA0, 8'hA8, 8'h28, 8'h00, 8'h88, 8'h20,
		8'h20, 8'h80, 8'h08, 8'hA0, 8'hA0, 8'h28, 8'h00, 8'hA8,
		8'h00, 8'h28, 8'hA8, 8'h88, 8'h08, 8'h80, 8'h28, 8'hA0,
		8'h28, 8'h88, 8'h20, 8'h08, 8'h88, 8'hA8, 8'h80, 8'h00,
		8'hA0, 8'h00, 8'h88, 8'hA8, 8'h20, 8'h08, 8'hA8, 8'h28,
		8'h88, 8'hA8, 8'h00, 8'h20, 8'h80, 8'h20, 8'h08, 8'hA8,
		8'h80, 8'h20, 8'h28, 8'h00, 8'hA8, 8'h88, 8'hA0, 8'h08,
		8'h08, 8'h80, 8'hA0, 8'h28, 8'h08, 8'h00, 8'h20, 8'h88,
		8'hA8, 8'h28, 8'h80, 8'h08, 8'hA0, 8'h80, 8'h28, 8'h00,
		8'h20, 8'hA0, 8'h08, 8'h80, 8'h28, 8'hA8, 8'h88, 8'h20,
		8'h88, 8'h08, 8'hA0, 8'hA8, 8'h00, 8'h20, 8'hA8, 8'h80
	};

	// --------------------
	// table index
	// --------------------

	// four address bits, the fetch type, then bits 5 and 3 folded with the flag
	function automatic logic [6:0] dec_index(
		input logic [14:0] adr,
		input logic        m1,
		input logic [7:0]  data
	);
		logic f;
		f = data[7];
		return {adr[12], adr[8], adr[4], adr[0], ~m1, data[5] ^ f, data[3] ^ f};
	endfunction

endpackage

`default_nettype wire

/* src/sys1_bus_pkg.sv */
// read source codes and map constants where I/O ports decode only adr[4:0] and mirror elsewhere
`default_nettype none

package sys1_bus_pkg;

	// --------------------
	// read sources
	// --------------------

	// src_none reads as open bus
	typedef enum logic [3:0] {
		src_video = 4'd0,
		src_in0   = 4'd1,
		src_in1   = 4'd2,
		src_in2   = 4'd3,
		src_dsw0  = 4'd4,
		src_dsw1  = 4'd5,
		src_ram   = 4'd6,
		src_rom   = 4'd7,
		src_none  = 4'd8
	} rd_src_t;

	// --------------------
	// I/O port codes
	// --------------------

	// write only ports
	localparam logic [4:0] io_snd_req  = 5'h18;
	localparam logic [4:0] io_vid_mode = 5'h19;

	// --------------------
	// memory map
	// --------------------

	// rom sits below 8000 and needs no constant
	localparam logic [3:0] ram_base_hi = 4'hC;

	// undriven data bus
	localparam logic [7:0] open_bus = 8'hFF;

endpackage

`default_nettype wire
